// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= func_units_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the testbench with Verilator, run it and check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -q "Simulation failed" $(LOG); then echo "Run FAILED"; exit 1; fi
	@if ! grep -q "Simulation completed successfully" $(LOG); then echo "Run incomplete"; exit 1; fi
	@echo "Run PASSED"

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
+incdir+src
src/fu_pkg.sv
src/cond_eval.sv
src/alu_unit.sv
src/dmem.sv
src/func_units.sv
tb/clk_gen.sv
tb/func_units_tb.sv

// ==== src/alu_unit.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module alu_unit
  import fu_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     rst_n,
  input  logic                     start,
  input  fu_op_t                   op,
  input  logic [`GPR_SIZE-1:0]     val_a,
  input  logic [`GPR_SIZE-1:0]     val_b,
  input  logic [`ROB_IDX_BITS-1:0] rob_index,
  input  logic                     set_nzcv_in,
  input  nzcv_t                    nzcv_in,
  input  cond_t                    cond,
  output logic                     done,
  output logic [`ROB_IDX_BITS-1:0] done_index,
  output logic [`GPR_SIZE-1:0]     value,
  output fu_op_t                   done_op,
  output logic                     set_nzcv,
  output nzcv_t                    nzcv_out,
  output logic                     condition
);

  localparam int MSB = `GPR_SIZE - 1;

  logic [`GPR_SIZE-1:0] a_q;
  logic [`GPR_SIZE-1:0] b_q;
  nzcv_t                nzcv_q;
  cond_t                cond_q;
  logic [`GPR_SIZE:0]   sum_ext;

  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      done <= 1'b0;
    end else begin
      done <= start;
    end
  end

  // Operands held until the next issue
  always_ff @(posedge in_clk) begin
    if (start) begin
      a_q        <= val_a;
      b_q        <= val_b;
      done_op    <= op;
      done_index <= rob_index;
      set_nzcv   <= set_nzcv_in;
      nzcv_q     <= nzcv_in;
      cond_q     <= cond;
    end
  end

  cond_eval cond_eval_i (
    .cond  (cond_q),
    .nzcv  (nzcv_q),
    .holds (condition)
  );

  // Extra bit catches the carry out of the add
  assign sum_ext = {1'b0, a_q} + {1'b0, b_q};

  always_comb begin
    case (done_op)
      FU_OP_PLUS,
      FU_OP_B_COND: value = sum_ext[MSB:0];
      FU_OP_MINUS:  value = a_q - b_q;
      FU_OP_AND:    value = a_q & b_q;
      FU_OP_OR:     value = a_q | b_q;
      FU_OP_EOR:    value = a_q ^ b_q;
      FU_OP_ORN:    value = a_q | ~b_q;
      FU_OP_MOV:    value = a_q | b_q;
      FU_OP_PASS_A: value = a_q;
      FU_OP_CSEL:   value = condition ? a_q : b_q;
      FU_OP_CSINC:  value = condition ? a_q : b_q + 1'b1;
      FU_OP_CSINV:  value = condition ? a_q : ~b_q;
      FU_OP_CSNEG:  value = condition ? a_q : -b_q;
      default:      value = '0;
    endcase
  end

  always_comb begin
    nzcv_out.n = value[MSB];
    nzcv_out.z = (value == '0);
    nzcv_out.c = 1'b0;
    nzcv_out.v = 1'b0;
    case (done_op)
      FU_OP_PLUS,
      FU_OP_B_COND: begin
        nzcv_out.c = sum_ext[`GPR_SIZE];
        // Same-sign operands, result sign flipped
        nzcv_out.v = (a_q[MSB] == b_q[MSB]) && (value[MSB] != a_q[MSB]);
      end
      FU_OP_MINUS: begin
        // No borrow
        nzcv_out.c = (a_q >= b_q);
        nzcv_out.v = (a_q[MSB] != b_q[MSB]) && (value[MSB] != a_q[MSB]);
      end
      default: begin
        nzcv_out.c = 1'b0;
        nzcv_out.v = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== src/cond_eval.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module cond_eval
  import fu_pkg::*;
(
  input  cond_t cond,
  input  nzcv_t nzcv,
  output logic  holds
);

  always_comb begin
    case (cond)
      EQ: holds = nzcv.z;
      NE: holds = ~nzcv.z;
      CS: holds = nzcv.c;
      CC: holds = ~nzcv.c;
      MI: holds = nzcv.n;
      PL: holds = ~nzcv.n;
      VS: holds = nzcv.v;
      VC: holds = ~nzcv.v;
      // Unsigned compares
      HI: holds = nzcv.c & ~nzcv.z;
      LS: holds = ~(nzcv.c & ~nzcv.z);
      // Signed compares
      GE: holds = (nzcv.n == nzcv.v);
      LT: holds = (nzcv.n != nzcv.v);
      GT: holds = ~nzcv.z & (nzcv.n == nzcv.v);
      LE: holds = ~(~nzcv.z & (nzcv.n == nzcv.v));
      default: holds = 1'b1;  // AL and NV
    endcase
  end

endmodule

`default_nettype wire

// ==== src/dmem.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module dmem #(
  parameter int DEPTH_BYTES = `DMEM_BYTES
) (
  input  logic                 in_clk,
  input  logic [`GPR_SIZE-1:0] addr,
  input  logic                 write_en,
  input  logic [`GPR_SIZE-1:0] wdata,
  output logic [`GPR_SIZE-1:0] rdata
);

  localparam int AW    = $clog2(DEPTH_BYTES);
  localparam int NBYTE = `GPR_SIZE / 8;

  logic [7:0]    mem [DEPTH_BYTES];
  logic [AW-1:0] addr_q;
  logic [AW-1:0] base;

  // Only the low bits select a byte, the rest wrap around
  assign base = addr[AW-1:0];

  always_ff @(posedge in_clk) begin
    addr_q <= base;
  end

  // Little-endian store, lowest byte at the lowest address
  always_ff @(posedge in_clk) begin
    if (write_en) begin
      for (int i = 0; i < NBYTE; i++) begin
        mem[base + AW'(i)] <= wdata[8*i +: 8];
      end
    end
  end

  // Read follows the registered address
  always_comb begin
    for (int i = 0; i < NBYTE; i++) begin
      rdata[8*i +: 8] = mem[addr_q + AW'(i)];
    end
  end

endmodule

`default_nettype wire

// ==== src/fu_pkg.sv ====
`default_nettype none

`include "fu_settings.svh"

package fu_pkg;

  // Operation codes shared by the ALU and load/store paths
  typedef enum logic [3:0] {
    FU_OP_PLUS,
    FU_OP_MINUS,
    FU_OP_AND,
    FU_OP_OR,
    FU_OP_EOR,
    FU_OP_ORN,
    FU_OP_MOV,
    FU_OP_PASS_A,
    FU_OP_CSEL,
    FU_OP_CSINC,
    FU_OP_CSINV,
    FU_OP_CSNEG,
    FU_OP_B_COND,
    FU_OP_LDUR,
    FU_OP_STUR
  } fu_op_t;

  // ARM condition codes, in architectural encoding order
  typedef enum logic [3:0] {
    EQ, NE, CS, CC, MI, PL, VS, VC,
    HI, LS, GE, LT, GT, LE, AL, NV
  } cond_t;

  typedef struct packed {
    logic n;
    logic z;
    logic c;
    logic v;
  } nzcv_t;

endpackage

`default_nettype wire

// ==== src/fu_settings.svh ====
`ifndef FU_SETTINGS_SVH
`define FU_SETTINGS_SVH

// Register and data path width
`define GPR_SIZE 64

// Width of a reorder buffer entry index
`define ROB_IDX_BITS 4

// Data memory size in bytes, a power of two
`define DMEM_BYTES 256

`endif

// ==== src/func_units.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module func_units
  import fu_pkg::*;
(
  input  logic                     in_clk,
  input  logic                     rst_n,
  // ALU issue
  input  logic                     alu_start,
  input  fu_op_t                   alu_op,
  input  logic [`GPR_SIZE-1:0]     alu_val_a,
  input  logic [`GPR_SIZE-1:0]     alu_val_b,
  input  logic [`ROB_IDX_BITS-1:0] alu_rob_index,
  input  logic                     alu_set_nzcv,
  input  nzcv_t                    alu_nzcv,
  input  cond_t                    alu_cond,
  // Load/store issue
  input  logic                     ls_start,
  input  fu_op_t                   ls_op,
  input  logic [`GPR_SIZE-1:0]     ls_addr,
  input  logic [`GPR_SIZE-1:0]     ls_wdata,
  input  logic [`ROB_IDX_BITS-1:0] ls_rob_index,
  // Result to the ROB
  output logic                     rob_done,
  output logic [`ROB_IDX_BITS-1:0] rob_index,
  output logic [`GPR_SIZE-1:0]     rob_value,
  output fu_op_t                   rob_op,
  output logic                     rob_set_nzcv,
  output nzcv_t                    rob_nzcv,
  output logic                     rob_condition
);

  logic                     alu_done;
  logic [`ROB_IDX_BITS-1:0] alu_done_index;
  logic [`GPR_SIZE-1:0]     alu_value;
  fu_op_t                   alu_done_op;
  logic                     alu_res_set_nzcv;
  nzcv_t                    alu_res_nzcv;
  logic                     alu_res_condition;

  logic                     ls_done;
  logic [`ROB_IDX_BITS-1:0] ls_done_index;
  fu_op_t                   ls_done_op;
  logic [`GPR_SIZE-1:0]     ls_rdata;
  logic                     dmem_we;

  alu_unit alu_unit_i (
    .in_clk      (in_clk),
    .rst_n       (rst_n),
    .start       (alu_start),
    .op          (alu_op),
    .val_a       (alu_val_a),
    .val_b       (alu_val_b),
    .rob_index   (alu_rob_index),
    .set_nzcv_in (alu_set_nzcv),
    .nzcv_in     (alu_nzcv),
    .cond        (alu_cond),
    .done        (alu_done),
    .done_index  (alu_done_index),
    .value       (alu_value),
    .done_op     (alu_done_op),
    .set_nzcv    (alu_res_set_nzcv),
    .nzcv_out    (alu_res_nzcv),
    .condition   (alu_res_condition)
  );

  // Stores write at the issue edge
  assign dmem_we = ls_start && (ls_op == FU_OP_STUR);

  dmem dmem_i (
    .in_clk   (in_clk),
    .addr     (ls_addr),
    .write_en (dmem_we),
    .wdata    (ls_wdata),
    .rdata    (ls_rdata)
  );

  always_ff @(posedge in_clk) begin
    if (!rst_n) begin
      ls_done <= 1'b0;
    end else begin
      ls_done <= ls_start;
    end
  end

  always_ff @(posedge in_clk) begin
    if (ls_start) begin
      ls_done_index <= ls_rob_index;
      ls_done_op    <= ls_op;
    end
  end

  // ALU has priority, the issue side keeps the two apart
  always_comb begin
    rob_done = alu_done | ls_done;
    if (alu_done) begin
      rob_index     = alu_done_index;
      rob_value     = alu_value;
      rob_op        = alu_done_op;
      rob_set_nzcv  = alu_res_set_nzcv;
      rob_nzcv      = alu_res_nzcv;
      rob_condition = alu_res_condition;
    end else begin
      rob_index     = ls_done_index;
      rob_value     = ls_rdata;
      rob_op        = ls_done_op;
      rob_set_nzcv  = 1'b0;
      rob_nzcv      = '0;
      rob_condition = 1'b0;
    end
  end

endmodule

`default_nettype wire

// ==== tb/clk_gen.sv ====
`timescale 1ns/1ps
`default_nettype none

module clk_gen #(
  parameter int HALF_PERIOD  = 10,
  parameter int RESET_CYCLES = 5
) (
  output logic in_clk,
  output logic rst_n
);

  initial begin
    in_clk = 1'b0;
    forever #HALF_PERIOD in_clk = ~in_clk;
  end

  // Release on a falling edge, away from the sampling edge
  initial begin
    rst_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge in_clk);
    @(negedge in_clk);
    rst_n = 1'b1;
  end

endmodule

`default_nettype wire

// ==== tb/func_units_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "fu_settings.svh"

module func_units_tb
  import fu_pkg::*;
;

  localparam int N_RAND = 16;
  localparam int SLOTS  = `DMEM_BYTES / 8;

  typedef logic [`GPR_SIZE-1:0] word_t;

  // One issued operation and what the ROB should see a cycle later
  typedef struct packed {
    logic   ls;
    fu_op_t op;
    word_t  a;
    word_t  b;
    nzcv_t  flags;
    cond_t  cond;
    logic   set_nzcv;
    word_t  exp_val;
    nzcv_t  exp_flags;
    logic   exp_cond;
  } row_t;

  logic                     in_clk;
  logic                     rst_n;
  logic                     alu_start;
  fu_op_t                   alu_op;
  word_t                    alu_val_a;
  word_t                    alu_val_b;
  logic [`ROB_IDX_BITS-1:0] alu_rob_index;
  logic                     alu_set_nzcv;
  nzcv_t                    alu_nzcv;
  cond_t                    alu_cond;
  logic                     ls_start;
  fu_op_t                   ls_op;
  word_t                    ls_addr;
  word_t                    ls_wdata;
  logic [`ROB_IDX_BITS-1:0] ls_rob_index;
  logic                     rob_done;
  logic [`ROB_IDX_BITS-1:0] rob_index;
  word_t                    rob_value;
  fu_op_t                   rob_op;
  logic                     rob_set_nzcv;
  nzcv_t                    rob_nzcv;
  logic                     rob_condition;

  row_t  rows[$];
  string names[$];
  int    checks;
  int    errors;
  int    cycles;
  int    cycle_limit;

  clk_gen clk_gen_i (
    .in_clk (in_clk),
    .rst_n  (rst_n)
  );

  func_units func_units_i (
    .in_clk        (in_clk),
    .rst_n         (rst_n),
    .alu_start     (alu_start),
    .alu_op        (alu_op),
    .alu_val_a     (alu_val_a),
    .alu_val_b     (alu_val_b),
    .alu_rob_index (alu_rob_index),
    .alu_set_nzcv  (alu_set_nzcv),
    .alu_nzcv      (alu_nzcv),
    .alu_cond      (alu_cond),
    .ls_start      (ls_start),
    .ls_op         (ls_op),
    .ls_addr       (ls_addr),
    .ls_wdata      (ls_wdata),
    .ls_rob_index  (ls_rob_index),
    .rob_done      (rob_done),
    .rob_index     (rob_index),
    .rob_value     (rob_value),
    .rob_op        (rob_op),
    .rob_set_nzcv  (rob_set_nzcv),
    .rob_nzcv      (rob_nzcv),
    .rob_condition (rob_condition)
  );

  task automatic alu_row(input string name, input fu_op_t op, input word_t a, input word_t b,
                         input nzcv_t flags, input cond_t cond, input logic set_nzcv,
                         input word_t val, input nzcv_t xflags, input logic xcond);
    row_t r;
    r = '{ls: 1'b0, op: op, a: a, b: b, flags: flags, cond: cond, set_nzcv: set_nzcv,
          exp_val: val, exp_flags: xflags, exp_cond: xcond};
    rows.push_back(r);
    names.push_back(name);
  endtask

  // Load/store results carry no flags and no condition
  task automatic mem_row(input string name, input fu_op_t op, input word_t addr,
                         input word_t data, input word_t val);
    row_t r;
    r = '{ls: 1'b1, op: op, a: addr, b: data, flags: 4'b0000, cond: AL, set_nzcv: 1'b0,
          exp_val: val, exp_flags: 4'b0000, exp_cond: 1'b0};
    rows.push_back(r);
    names.push_back(name);
  endtask

  task automatic build_table();
    alu_row("add_basic", FU_OP_PLUS, 64'd5, 64'd7, 4'b0000, AL, 1'b1, 64'd12, 4'b0000, 1'b1);
    alu_row("add_wrap", FU_OP_PLUS, 64'hFFFF_FFFF_FFFF_FFFF, 64'd1, 4'b0000, AL, 1'b1,
            64'd0, 4'b0110, 1'b1);
    alu_row("add_ovf", FU_OP_PLUS, 64'h7FFF_FFFF_FFFF_FFFF, 64'd1, 4'b0000, AL, 1'b1,
            64'h8000_0000_0000_0000, 4'b1001, 1'b1);
    alu_row("sub_basic", FU_OP_MINUS, 64'd10, 64'd3, 4'b0000, AL, 1'b0, 64'd7, 4'b0010, 1'b1);
    alu_row("sub_wrap", FU_OP_MINUS, 64'd3, 64'd10, 4'b0000, AL, 1'b1,
            64'hFFFF_FFFF_FFFF_FFF9, 4'b1000, 1'b1);
    alu_row("sub_zero", FU_OP_MINUS, 64'h1234, 64'h1234, 4'b0000, AL, 1'b1, 64'd0, 4'b0110, 1'b1);
    alu_row("sub_ovf", FU_OP_MINUS, 64'h8000_0000_0000_0000, 64'd1, 4'b0000, AL, 1'b1,
            64'h7FFF_FFFF_FFFF_FFFF, 4'b0011, 1'b1);
    alu_row("and", FU_OP_AND, 64'hF0F0_F0F0_F0F0_F0F0, 64'hFF00_FF00_FF00_FF00, 4'b0000, AL,
            1'b0, 64'hF000_F000_F000_F000, 4'b1000, 1'b1);
    alu_row("or", FU_OP_OR, 64'hF0, 64'h3C, 4'b0000, AL, 1'b1, 64'hFC, 4'b0000, 1'b1);
    alu_row("eor", FU_OP_EOR, 64'hFFFF_0000_FFFF_0000, 64'hFFFF_FFFF_0000_0000, 4'b0000, AL,
            1'b1, 64'h0000_FFFF_FFFF_0000, 4'b0000, 1'b1);
    alu_row("eor_zero", FU_OP_EOR, 64'hABCD, 64'hABCD, 4'b0000, AL, 1'b1, 64'd0, 4'b0100, 1'b1);
    alu_row("orn", FU_OP_ORN, 64'd0, 64'hFFFF_FFFF_FFFF_FF00, 4'b0000, AL, 1'b1,
            64'hFF, 4'b0000, 1'b1);
    alu_row("mov", FU_OP_MOV, 64'hFF, 64'h1234_5678_9ABC_DEF0, 4'b0000, AL, 1'b0,
            64'h1234_5678_9ABC_DEFF, 4'b0000, 1'b1);
    alu_row("pass_a", FU_OP_PASS_A, 64'h8000_0000_0000_0001, 64'h55, 4'b0000, AL, 1'b1,
            64'h8000_0000_0000_0001, 4'b1000, 1'b1);
    // Memory and selects alternate from here on
    mem_row("st_10", FU_OP_STUR, 64'h10, 64'h0807_0605_0403_0201, 64'h0807_0605_0403_0201);
    alu_row("csel_eq_hold", FU_OP_CSEL, 64'h11, 64'h22, 4'b0100, EQ, 1'b0, 64'h11, 4'b0000, 1'b1);
    mem_row("ld_10", FU_OP_LDUR, 64'h10, 64'd0, 64'h0807_0605_0403_0201);
    alu_row("csel_eq_fail", FU_OP_CSEL, 64'h11, 64'h22, 4'b0000, EQ, 1'b0, 64'h22, 4'b0000, 1'b0);
    mem_row("st_18", FU_OP_STUR, 64'h18, 64'h1817_1615_1413_1211, 64'h1817_1615_1413_1211);
    alu_row("csinc_hi_hold", FU_OP_CSINC, 64'h11, 64'h22, 4'b0010, HI, 1'b1, 64'h11, 4'b0000, 1'b1);
    mem_row("ld_14", FU_OP_LDUR, 64'h14, 64'd0, 64'h1413_1211_0807_0605);
    alu_row("csinc_hi_fail", FU_OP_CSINC, 64'h11, 64'h22, 4'b0110, HI, 1'b1, 64'h23, 4'b0000, 1'b0);
    mem_row("st_14", FU_OP_STUR, 64'h14, 64'hA7A6_A5A4_A3A2_A1A0, 64'hA7A6_A5A4_A3A2_A1A0);
    alu_row("csinc_wrap", FU_OP_CSINC, 64'h5, 64'hFFFF_FFFF_FFFF_FFFF, 4'b0100, NE, 1'b1,
            64'd0, 4'b0100, 1'b0);
    mem_row("ld_10_overlap", FU_OP_LDUR, 64'h10, 64'd0, 64'hA3A2_A1A0_0403_0201);
    alu_row("csinv_ge_hold", FU_OP_CSINV, 64'h5, 64'hF, 4'b1001, GE, 1'b1, 64'h5, 4'b0000, 1'b1);
    mem_row("ld_18_overlap", FU_OP_LDUR, 64'h18, 64'd0, 64'h1817_1615_A7A6_A5A4);
    alu_row("csinv_lt_fail", FU_OP_CSINV, 64'h5, 64'hF, 4'b1001, LT, 1'b1,
            64'hFFFF_FFFF_FFFF_FFF0, 4'b1000, 1'b0);
    // Upper address bits fall away in the memory
    mem_row("st_alias", FU_OP_STUR, 64'h0000_0001_0000_0040, 64'hDEAD_BEEF_CAFE_F00D,
            64'hDEAD_BEEF_CAFE_F00D);
    alu_row("csneg_gt_hold", FU_OP_CSNEG, 64'h7, 64'h3, 4'b0000, GT, 1'b1, 64'h7, 4'b0000, 1'b1);
    mem_row("ld_alias", FU_OP_LDUR, 64'h40, 64'd0, 64'hDEAD_BEEF_CAFE_F00D);
    alu_row("csneg_le_fail", FU_OP_CSNEG, 64'h7, 64'h3, 4'b0000, LE, 1'b1,
            64'hFFFF_FFFF_FFFF_FFFD, 4'b1000, 1'b0);
    alu_row("csel_vs_hold", FU_OP_CSEL, 64'd0, 64'd1, 4'b0001, VS, 1'b1, 64'd0, 4'b0100, 1'b1);
    alu_row("csel_vc_fail", FU_OP_CSEL, 64'h8, 64'h9, 4'b0001, VC, 1'b1, 64'h9, 4'b0000, 1'b0);
    alu_row("csel_cs_hold", FU_OP_CSEL, 64'h8, 64'h9, 4'b0010, CS, 1'b1, 64'h8, 4'b0000, 1'b1);
    alu_row("csel_cc_fail", FU_OP_CSEL, 64'd0, 64'd1, 4'b0010, CC, 1'b1, 64'd1, 4'b0000, 1'b0);
    alu_row("csel_mi_hold", FU_OP_CSEL, 64'h33, 64'h44, 4'b1000, MI, 1'b1, 64'h33, 4'b0000, 1'b1);
    alu_row("csel_pl_fail", FU_OP_CSEL, 64'h33, 64'h44, 4'b1000, PL, 1'b1, 64'h44, 4'b0000, 1'b0);
    alu_row("csel_nv", FU_OP_CSEL, 64'h42, 64'h24, 4'b0000, NV, 1'b1, 64'h42, 4'b0000, 1'b1);
    alu_row("bcond_ne_hold", FU_OP_B_COND, 64'h100, 64'h20, 4'b0000, NE, 1'b0,
            64'h120, 4'b0000, 1'b1);
    alu_row("bcond_ls_hold", FU_OP_B_COND, 64'h100, 64'hFFFF_FFFF_FFFF_FFF0, 4'b0100, LS, 1'b0,
            64'hF0, 4'b0010, 1'b1);
    alu_row("bcond_eq_fail", FU_OP_B_COND, 64'd1, 64'd2, 4'b0000, EQ, 1'b0, 64'd3, 4'b0000, 1'b0);
    alu_row("bcond_le_hold", FU_OP_B_COND, 64'h8000_0000_0000_0000, 64'h8000_0000_0000_0000,
            4'b1000, LE, 1'b1, 64'd0, 4'b0111, 1'b1);
  endtask

  // Stores to random aligned slots, then loads of written slots
  task automatic add_random();
    word_t model [SLOTS];
    bit    written [SLOTS];
    int    slot;
    word_t data;
    for (int k = 0; k < N_RAND; k++) begin
      slot = $urandom % SLOTS;
      data = {$urandom, $urandom};
      model[slot]   = data;
      written[slot] = 1'b1;
      mem_row($sformatf("rand_st_%0d", k), FU_OP_STUR, word_t'(slot * 8), data, data);
    end
    for (int k = 0; k < N_RAND; k++) begin
      slot = $urandom % SLOTS;
      while (!written[slot]) begin
        slot = (slot + 1) % SLOTS;
      end
      mem_row($sformatf("rand_ld_%0d", k), FU_OP_LDUR, word_t'(slot * 8), '0, model[slot]);
    end
  endtask

  task automatic drive_row(input int n);
    row_t r;
    r = rows[n];
    alu_start     = ~r.ls;
    ls_start      = r.ls;
    alu_op        = r.op;
    ls_op         = r.op;
    alu_val_a     = r.a;
    alu_val_b     = r.b;
    ls_addr       = r.a;
    ls_wdata      = r.b;
    alu_rob_index = (`ROB_IDX_BITS)'(n);
    ls_rob_index  = (`ROB_IDX_BITS)'(n);
    alu_set_nzcv  = r.set_nzcv;
    alu_nzcv      = r.flags;
    alu_cond      = r.cond;
  endtask

  task automatic report_value(input string name, input string field,
                              input word_t exp, input word_t act);
    errors++;
    $display("[FAIL] %s %s: expected %h, actual %h", name, field, exp, act);
  endtask

  task automatic check_result(input int n);
    row_t                     r;
    logic [`ROB_IDX_BITS-1:0] idx;
    r   = rows[n];
    idx = (`ROB_IDX_BITS)'(n);
    checks++;
    assert (rob_done === 1'b1) else begin
      errors++;
      $display("No result pulse from the DUT for %s", names[n]);
    end
    assert (rob_index === idx)
      else report_value(names[n], "index", word_t'(idx), word_t'(rob_index));
    assert (rob_op === r.op)
      else report_value(names[n], "op", word_t'(r.op), word_t'(rob_op));
    assert (rob_value === r.exp_val)
      else report_value(names[n], "value", r.exp_val, rob_value);
    assert (rob_nzcv === r.exp_flags)
      else report_value(names[n], "nzcv", word_t'(r.exp_flags), word_t'(rob_nzcv));
    assert (rob_set_nzcv === r.set_nzcv)
      else report_value(names[n], "set_nzcv", word_t'(r.set_nzcv), word_t'(rob_set_nzcv));
    assert (rob_condition === r.exp_cond)
      else report_value(names[n], "condition", word_t'(r.exp_cond), word_t'(rob_condition));
  endtask

  task automatic check_idle(input string phase);
    checks++;
    assert (rob_done === 1'b0) else begin
      errors++;
      $display("Result pulse seen with nothing issued, %s", phase);
    end
  endtask

  always @(posedge in_clk) begin
    cycles = cycles + 1;
    if (cycles >= cycle_limit) begin
      $display("Timeout, the run did not end within %0d cycles", cycle_limit);
      $display("Simulation failed");
      $finish;
    end
  end

  initial begin
    alu_start     = 1'b0;
    alu_op        = FU_OP_PLUS;
    alu_val_a     = '0;
    alu_val_b     = '0;
    alu_rob_index = '0;
    alu_set_nzcv  = 1'b0;
    alu_nzcv      = '0;
    alu_cond      = AL;
    ls_start      = 1'b0;
    ls_op         = FU_OP_LDUR;
    ls_addr       = '0;
    ls_wdata      = '0;
    ls_rob_index  = '0;
    checks        = 0;
    errors        = 0;
    cycles        = 0;
    void'($urandom(30025));
    build_table();
    cycle_limit = rows.size() + 2 * N_RAND + 20;
    add_random();

    wait (rst_n === 1'b1);
    repeat (3) begin
      @(negedge in_clk);
      check_idle("after reset");
    end

    // One row per cycle, the previous row checked before the next is driven
    for (int n = 0; n < rows.size(); n++) begin
      @(negedge in_clk);
      if (n > 0) begin
        check_result(n - 1);
      end
      drive_row(n);
    end
    @(negedge in_clk);
    check_result(rows.size() - 1);
    alu_start = 1'b0;
    ls_start  = 1'b0;
    repeat (2) begin
      @(negedge in_clk);
      check_idle("after the last issue");
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire
